// File: sdrc_settings.svh
`ifndef SDRC_SETTINGS_SVH
`define SDRC_SETTINGS_SVH

// ------------------------------------------------
// Bus widths
// ------------------------------------------------

// Wishbone and SDRAM data word
`define SDRC_DW 32

// Application word address
`define SDRC_APP_AW 26

// One enable per byte lane
`define SDRC_BE_W (`SDRC_DW / 8)

// ------------------------------------------------
// Queue depths
// ------------------------------------------------

// Address plus direction entries
`define SDRC_CMD_DEPTH 4
// Data plus byte enable beats
`define SDRC_WR_DEPTH 8
// Returned read words
`define SDRC_RD_DEPTH 4

`endif

// File: sdrc_pkg.sv
package sdrc_pkg;

  `include "sdrc_settings.svh"

  // ------------------------------------------------
  // Vector types
  // ------------------------------------------------

  // Application word address
  typedef logic [`SDRC_APP_AW-1:0] app_addr_t;

  // Data word, shared by Wishbone and SDRAM sides
  typedef logic [`SDRC_DW-1:0] wb_data_t;

  // Byte lanes
  // Active high on Wishbone, active low towards the SDRAM controller
  typedef logic [`SDRC_BE_W-1:0] byte_en_t;

  // Queued command
  // Top bit is the read flag, same sense as sdr_req_wr_n
  // Lower bits carry the word address
  typedef logic [`SDRC_APP_AW:0] sdr_cmd_t;

  // Queued write beat
  // Active-low byte enables sit above the data word
  typedef logic [`SDRC_BE_W+`SDRC_DW-1:0] wr_beat_t;

  // ------------------------------------------------
  // Read tracker states
  // ------------------------------------------------
  typedef enum logic {
    RD_IDLE    = 1'b0,
    RD_PENDING = 1'b1
  } rd_state_e;

endpackage

// File: sdrc_fifo.sv
`timescale 1ns/1ps

module sdrc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             sdram_clk,
  input  logic             wb_clk_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] pop_data_o,
  output logic             full_o,
  output logic             empty_o
);

  // ------------------------------------------------
  // Sizing
  // ------------------------------------------------

  // Pointer needs at least one bit, even for a single entry
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // Count spans 0 to DEPTH inclusive
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Wrap point of both pointers
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  // Occupancy at which the queue is full
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  // Storage, written at the tail, read at the head
  logic [WIDTH-1:0] mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic             full_q;
  logic             empty_q;

  // Circular increment, also correct for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == LAST_PTR) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ------------------------------------------------
  // Occupancy
  // ------------------------------------------------

  // Push and pop together leave the count alone
  always_comb begin
    count_d = count_q;
    if (push_i && !pop_i) begin
      count_d = count_q + 1'b1;
    end else if (pop_i && !push_i) begin
      count_d = count_q - 1'b1;
    end
  end

  // Pointers, count and flags
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_d;
      // Flags registered from the next count
      full_q  <= (count_d == FULL_CNT);
      empty_q <= (count_d == '0);
    end
  end

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  // Tail write on every push
  always_ff @(posedge sdram_clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Show-ahead head, valid whenever not empty
  assign pop_data_o = mem_q[rd_ptr_q];

  assign full_o  = full_q;
  assign empty_o = empty_q;

endmodule

// File: wb_req_ctrl.sv
`timescale 1ns/1ps

module wb_req_ctrl (
  input  logic sdram_clk,
  input  logic wb_clk_i,
  // Wishbone request
  input  logic wb_stb_i,
  input  logic wb_cyc_i,
  input  logic wb_we_i,
  // Queue status
  input  logic cmd_full_i,
  input  logic wdata_full_i,
  input  logic rdata_empty_i,
  // Acknowledge and queue strobes
  output logic wb_ack_o,
  output logic cmd_push_o,
  output logic wdata_push_o,
  output logic rdata_pop_o
);

  import sdrc_pkg::*;

  // Decoded request phases
  logic      wb_req;
  logic      wr_req;
  logic      rd_req;

  // Write can go when both queues have room
  logic      wr_room;
  // Write accepted this cycle
  logic      wr_ack;
  // Read command queued this cycle
  logic      rd_cmd_push;
  // Read data handed back this cycle
  logic      rd_ack;

  rd_state_e rd_state_q;
  rd_state_e rd_state_d;

  // ------------------------------------------------
  // Request decode
  // ------------------------------------------------
  assign wb_req = wb_stb_i && wb_cyc_i;
  assign wr_req = wb_req && wb_we_i;
  assign rd_req = wb_req && !wb_we_i;

  // ------------------------------------------------
  // Write path
  // ------------------------------------------------

  // Command and data beat pushed together
  assign wr_room = !cmd_full_i && !wdata_full_i;
  assign wr_ack  = wr_req && wr_room;

  // ------------------------------------------------
  // Read path
  // ------------------------------------------------

  // Only one read command outstanding at a time
  assign rd_cmd_push = rd_req && !cmd_full_i && (rd_state_q == RD_IDLE);

  // Ack comes together with the returned word
  assign rd_ack = rd_req && !rdata_empty_i;

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------
  assign wb_ack_o     = wr_ack || rd_ack;
  assign cmd_push_o   = wr_ack || rd_cmd_push;
  assign wdata_push_o = wr_ack;
  assign rdata_pop_o  = rd_ack;

  // ------------------------------------------------
  // Pending-read tracker
  // ------------------------------------------------

  // Set on read command push, cleared on read ack
  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      RD_IDLE: begin
        if (rd_cmd_push) begin
          rd_state_d = RD_PENDING;
        end
      end
      RD_PENDING: begin
        if (rd_ack) begin
          rd_state_d = RD_IDLE;
        end
      end
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      rd_state_q <= RD_IDLE;
    end else begin
      rd_state_q <= rd_state_d;
    end
  end

endmodule

// File: wb2sdrc.sv
`timescale 1ns/1ps

`include "sdrc_settings.svh"

module wb2sdrc (
  input  logic                sdram_clk,
  input  logic                wb_clk_i,
  // Wishbone slave
  input  logic                wb_stb_i,
  input  logic                wb_cyc_i,
  // 1 for write, 0 for read
  input  logic                wb_we_i,
  input  sdrc_pkg::app_addr_t wb_addr_i,
  input  sdrc_pkg::wb_data_t  wb_dat_i,
  // Active-high byte selects
  input  sdrc_pkg::byte_en_t  wb_sel_i,
  output logic                wb_ack_o,
  output sdrc_pkg::wb_data_t  wb_dat_o,
  // SDRAM controller request
  output logic                sdr_req_o,
  output sdrc_pkg::app_addr_t sdr_req_addr_o,
  // 0 for write, 1 for read
  output logic                sdr_req_wr_n_o,
  input  logic                sdr_req_ack_i,
  // SDRAM controller write data
  output sdrc_pkg::byte_en_t  sdr_wr_en_n_o,
  output sdrc_pkg::wb_data_t  sdr_wr_data_o,
  input  logic                sdr_wr_next_i,
  // SDRAM controller read data
  input  logic                sdr_rd_valid_i,
  input  sdrc_pkg::wb_data_t  sdr_rd_data_i
);

  import sdrc_pkg::*;

  // Queue status
  logic     cmd_full;
  logic     cmd_empty;
  logic     wdata_full;
  logic     rdata_empty;

  // Application side strobes
  logic     cmd_push;
  logic     wdata_push;
  logic     rdata_pop;

  // Packed queue entries and heads
  sdr_cmd_t cmd_entry;
  sdr_cmd_t cmd_head;
  wr_beat_t wbeat_entry;
  wr_beat_t wbeat_head;

  // ------------------------------------------------
  // Acknowledge and push/pop control
  // ------------------------------------------------
  wb_req_ctrl u_req_ctrl (
    .sdram_clk     (sdram_clk),
    .wb_clk_i      (wb_clk_i),
    .wb_stb_i      (wb_stb_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_we_i       (wb_we_i),
    .cmd_full_i    (cmd_full),
    .wdata_full_i  (wdata_full),
    .rdata_empty_i (rdata_empty),
    .wb_ack_o      (wb_ack_o),
    .cmd_push_o    (cmd_push),
    .wdata_push_o  (wdata_push),
    .rdata_pop_o   (rdata_pop)
  );

  // ------------------------------------------------
  // Command queue
  // ------------------------------------------------

  // Read flag above the word address
  assign cmd_entry = {!wb_we_i, wb_addr_i};

  sdrc_fifo #(
    .WIDTH ($bits(sdr_cmd_t)),
    .DEPTH (`SDRC_CMD_DEPTH)
  ) u_cmd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (cmd_push),
    .push_data_i (cmd_entry),
    // Controller accept pops the head
    .pop_i       (sdr_req_ack_i),
    .pop_data_o  (cmd_head),
    .full_o      (cmd_full),
    .empty_o     (cmd_empty)
  );

  // Request held while anything is queued
  assign sdr_req_o      = !cmd_empty;
  assign sdr_req_wr_n_o = cmd_head[`SDRC_APP_AW];
  assign sdr_req_addr_o = cmd_head[`SDRC_APP_AW-1:0];

  // ------------------------------------------------
  // Write data queue
  // ------------------------------------------------

  // Byte selects flipped to the controller's active-low enables
  assign wbeat_entry = {~wb_sel_i, wb_dat_i};

  sdrc_fifo #(
    .WIDTH ($bits(wr_beat_t)),
    .DEPTH (`SDRC_WR_DEPTH)
  ) u_wdata_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (wdata_push),
    .push_data_i (wbeat_entry),
    // One beat per write-next pulse
    .pop_i       (sdr_wr_next_i),
    .pop_data_o  (wbeat_head),
    .full_o      (wdata_full),
    .empty_o     ()
  );

  assign sdr_wr_en_n_o = wbeat_head[`SDRC_DW +: `SDRC_BE_W];
  assign sdr_wr_data_o = wbeat_head[`SDRC_DW-1:0];

  // ------------------------------------------------
  // Read data queue
  // ------------------------------------------------

  // Filled on read-valid, drained on read ack
  sdrc_fifo #(
    .WIDTH ($bits(wb_data_t)),
    .DEPTH (`SDRC_RD_DEPTH)
  ) u_rdata_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (sdr_rd_data_i),
    .pop_i       (rdata_pop),
    // Head goes straight to the Wishbone data bus
    .pop_data_o  (wb_dat_o),
    .full_o      (),
    .empty_o     (rdata_empty)
  );

endmodule

// File: tb_sdram_model.sv
`timescale 1ns/1ps

module tb_sdram_model (
  input  logic                sdram_clk,
  input  logic                wb_clk_i,
  // Withholds request acknowledges while high
  input  logic                hold_i,
  input  logic                sdr_req_i,
  input  sdrc_pkg::app_addr_t sdr_req_addr_i,
  input  logic                sdr_req_wr_n_i,
  input  sdrc_pkg::byte_en_t  sdr_wr_en_n_i,
  input  sdrc_pkg::wb_data_t  sdr_wr_data_i,
  output logic                sdr_req_ack_o,
  output logic                sdr_wr_next_o,
  output logic                sdr_rd_valid_o,
  output sdrc_pkg::wb_data_t  sdr_rd_data_o
);

  import sdrc_pkg::*;

  // 64 words, indexed by the low address bits
  wb_data_t   mem [64];
  // Accepted commands, oldest first
  sdr_cmd_t   cmd_log [64];
  int         log_count;
  integer     seed;
  int         wait_cyc;
  logic [5:0] idx;
  logic       rd_cmd;

  // Outputs change 2 ns after the rising edge
  task automatic next_cyc();
    @(posedge sdram_clk);
    #2;
  endtask

  initial begin
    seed           = 60;
    log_count      = 0;
    sdr_req_ack_o  = 1'b0;
    sdr_wr_next_o  = 1'b0;
    sdr_rd_valid_o = 1'b0;
    sdr_rd_data_o  = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h5A00_0000 ^ (i * 32'h0103_0507);
    end
    wait (!wb_clk_i);
    forever begin
      next_cyc();
      if (sdr_req_i && !hold_i) begin
        // Accept after 0 to 3 cycles
        wait_cyc = {$random(seed)} % 4;
        repeat (wait_cyc) next_cyc();
        idx    = sdr_req_addr_i[5:0];
        rd_cmd = sdr_req_wr_n_i;
        cmd_log[log_count] = {sdr_req_wr_n_i, sdr_req_addr_i};
        log_count++;
        sdr_req_ack_o = 1'b1;
        // Write beat taken in the same cycle as its command
        sdr_wr_next_o = !rd_cmd;
        for (int b = 0; b < 4; b++) begin
          if (!rd_cmd && !sdr_wr_en_n_i[b]) begin
            mem[idx][8*b +: 8] = sdr_wr_data_i[8*b +: 8];
          end
        end
        next_cyc();
        sdr_req_ack_o = 1'b0;
        sdr_wr_next_o = 1'b0;
        if (rd_cmd) begin
          // Read word comes back 2 to 5 cycles after the accept
          wait_cyc = 2 + {$random(seed)} % 4;
          repeat (wait_cyc - 1) next_cyc();
          sdr_rd_data_o  = mem[idx];
          sdr_rd_valid_o = 1'b1;
          next_cyc();
          sdr_rd_valid_o = 1'b0;
        end
      end
    end
  end

endmodule

// File: tb_wb2sdrc.sv
`timescale 1ns/1ps

`include "sdrc_settings.svh"

module tb_wb2sdrc;

  import sdrc_pkg::*;

  localparam int N_TAB   = 9;
  // One write more than the command queue holds
  localparam int N_HOLD  = `SDRC_CMD_DEPTH + 1;
  // Table entries plus hold writes and their read-backs
  localparam int MAX_CYC = (N_TAB + 2 * N_HOLD) * 40 + 200;

  logic      sdram_clk;
  logic      wb_clk_i;
  logic      wb_stb_i;
  logic      wb_cyc_i;
  logic      wb_we_i;
  app_addr_t wb_addr_i;
  wb_data_t  wb_dat_i;
  byte_en_t  wb_sel_i;
  logic      wb_ack_o;
  wb_data_t  wb_dat_o;
  logic      sdr_req_o;
  app_addr_t sdr_req_addr_o;
  logic      sdr_req_wr_n_o;
  logic      sdr_req_ack_i;
  byte_en_t  sdr_wr_en_n_o;
  wb_data_t  sdr_wr_data_o;
  logic      sdr_wr_next_i;
  logic      sdr_rd_valid_i;
  wb_data_t  sdr_rd_data_i;
  // Stalls the SDRAM model's request acknowledges
  logic      hold;

  // Stimulus table with expected read words
  string     t_name [N_TAB];
  logic      t_we   [N_TAB];
  app_addr_t t_addr [N_TAB];
  wb_data_t  t_data [N_TAB];
  byte_en_t  t_sel  [N_TAB];
  wb_data_t  t_exp  [N_TAB];
  int        n_tab;
  // Expected memory contents
  wb_data_t  shadow [64];
  int        cyc_cnt;

  wb2sdrc u_wb2sdrc (.*);

  tb_sdram_model u_sdram_model (
    .sdram_clk      (sdram_clk),
    .wb_clk_i       (wb_clk_i),
    .hold_i         (hold),
    .sdr_req_i      (sdr_req_o),
    .sdr_req_addr_i (sdr_req_addr_o),
    .sdr_req_wr_n_i (sdr_req_wr_n_o),
    .sdr_wr_en_n_i  (sdr_wr_en_n_o),
    .sdr_wr_data_i  (sdr_wr_data_o),
    .sdr_req_ack_o  (sdr_req_ack_i),
    .sdr_wr_next_o  (sdr_wr_next_i),
    .sdr_rd_valid_o (sdr_rd_valid_i),
    .sdr_rd_data_o  (sdr_rd_data_i)
  );

  // 20 ns clock period
  always #10 sdram_clk = ~sdram_clk;

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  always @(posedge sdram_clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt >= MAX_CYC) begin
      $display("Run timed out after %0d cycles without finishing", MAX_CYC);
      $display("Result: FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  // --------------------------------------------------
  // Table, bus and compare tasks
  // --------------------------------------------------
  task automatic add_entry(input string name, input logic we, input app_addr_t addr,
                           input wb_data_t data, input byte_en_t sel);
    t_name[n_tab] = name;
    t_we[n_tab]   = we;
    t_addr[n_tab] = addr;
    t_data[n_tab] = data;
    t_sel[n_tab]  = sel;
    // Reads expect the current word
    t_exp[n_tab]  = shadow[addr[5:0]];
    // Writes merge only the selected lanes
    for (int b = 0; b < `SDRC_BE_W; b++) begin
      if (we && sel[b]) begin
        shadow[addr[5:0]][8*b +: 8] = data[8*b +: 8];
      end
    end
    n_tab++;
  endtask

  // Wishbone request held until acknowledged
  task automatic start_req(input logic we, input app_addr_t addr, input wb_data_t data,
                           input byte_en_t sel);
    wb_stb_i  = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_we_i   = we;
    wb_addr_i = addr;
    wb_dat_i  = data;
    wb_sel_i  = sel;
  endtask

  // Ack sampled at the falling edge where it is stable
  task automatic wait_ack(output wb_data_t rdata);
    @(negedge sdram_clk);
    while (!wb_ack_o) @(negedge sdram_clk);
    rdata = wb_dat_o;
    @(posedge sdram_clk);
    #2;
  endtask

  task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_cmd(input string name, input sdr_cmd_t exp, input sdr_cmd_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    wb_data_t rdata;
    sdram_clk = 1'b0;
    wb_clk_i  = 1'b1;
    start_req(1'b0, '0, '0, '0);
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    hold      = 1'b0;
    n_tab     = 0;
    cyc_cnt   = 0;
    // Same fill as the SDRAM model
    for (int i = 0; i < 64; i++) begin
      shadow[i] = 32'h5A00_0000 ^ (i * 32'h0103_0507);
    end
    add_entry("wr_full_a", 1'b1, 26'd3, 32'hDEAD_BEEF, 4'hF);
    add_entry("wr_full_b", 1'b1, 26'd10, 32'h1234_5678, 4'hF);
    add_entry("rd_full_a", 1'b0, 26'd3, '0, '0);
    add_entry("rd_full_b", 1'b0, 26'd10, '0, '0);
    add_entry("wr_part_a", 1'b1, 26'd3, 32'hAABB_CCDD, 4'b0101);
    add_entry("rd_part_a", 1'b0, 26'd3, '0, '0);
    add_entry("rd_init", 1'b0, 26'd20, '0, '0);
    // Write then read with no gap
    add_entry("wr_b2b", 1'b1, 26'd33, 32'h0F1E_2D3C, 4'hF);
    add_entry("rd_b2b", 1'b0, 26'd33, '0, '0);
    // Reset for 4 cycles
    repeat (4) @(posedge sdram_clk);
    #2;
    wb_clk_i = 1'b0;
    check_flag("reset sdr_req", 1'b0, sdr_req_o);
    check_flag("reset wb_ack", 1'b0, wb_ack_o);
    for (int i = 0; i < N_TAB; i++) begin
      start_req(t_we[i], t_addr[i], t_data[i], t_sel[i]);
      wait_ack(rdata);
      if (!t_we[i]) begin
        check_data(t_name[i], t_exp[i], rdata);
      end
    end
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    // Command log in table order with the read flag on top
    check_count("log length", N_TAB, u_sdram_model.log_count);
    for (int i = 0; i < N_TAB; i++) begin
      check_cmd(t_name[i], {!t_we[i], t_addr[i]}, u_sdram_model.cmd_log[i]);
    end
    // Controller holds off until the command queue fills
    hold = 1'b1;
    for (int k = 0; k < N_HOLD; k++) begin
      shadow[40 + k] = 32'hB000_0000 + k * 32'h0101_0101;
      start_req(1'b1, app_addr_t'(40 + k), shadow[40 + k], 4'hF);
      if (k < N_HOLD - 1) begin
        wait_ack(rdata);
      end
    end
    // Last write stalled while the first request stays on the bus
    repeat (6) begin
      @(negedge sdram_clk);
      check_flag("hold extra ack", 1'b0, wb_ack_o);
      check_flag("hold sdr_req", 1'b1, sdr_req_o);
      check_cmd("hold head", {1'b0, app_addr_t'(40)}, {sdr_req_wr_n_o, sdr_req_addr_o});
    end
    @(posedge sdram_clk);
    #2;
    hold = 1'b0;
    wait_ack(rdata);
    // Read back every held write
    for (int k = 0; k < N_HOLD; k++) begin
      start_req(1'b0, app_addr_t'(40 + k), '0, '0);
      wait_ack(rdata);
      check_data("rd_hold", shadow[40 + k], rdata);
    end
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
sdrc_pkg.sv
sdrc_fifo.sv
wb_req_ctrl.sv
wb2sdrc.sv
tb_sdram_model.sv
tb_wb2sdrc.sv

// File: Bender.yml
package:
  name: wb2sdrc

sources:
  - include_dirs:
      - .
    files:
      - sdrc_pkg.sv
      - sdrc_fifo.sv
      - wb_req_ctrl.sv
      - wb2sdrc.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sdram_model.sv
      - tb_wb2sdrc.sv
